// File: fwrisc_exec_consts.svh
`ifndef FWRISC_EXEC_CONSTS_SVH
`define FWRISC_EXEC_CONSTS_SVH

// width of the data path, register values and operands.
`define FWRISC_XLEN 32

// destination register address width.
// six bits cover the CSR space of the parent core as well as x0..x31.
`define FWRISC_RADDR_W 6

// width of the ALU operation code carried from decode.
`define FWRISC_OP_W 6

// width of a shift amount, taken from the low bits of op_b.
`define FWRISC_SHAMT_W 5

// program counter after reset.
// the pc is held as a halfword address, so this is the byte address 0x8000_0000 shifted by one.
`define FWRISC_RESET_VEC 31'h4000_0000

`endif

// File: fwrisc_exec_pkg.sv
`include "fwrisc_exec_consts.svh"

package fwrisc_exec_pkg;

	// instruction class, as decode reports it.
	typedef enum logic [4:0] {
		op_type_arith = 5'd0,
		op_type_shift = 5'd1,
		op_type_jump  = 5'd2
	} exec_op_type_t;

	// operation within a class.
	// the arithmetic codes come first, the shift codes follow.
	typedef enum logic [`FWRISC_OP_W-1:0] {
		op_add = 6'd0,
		op_sub = 6'd1,
		op_and = 6'd2,
		op_or  = 6'd3,
		op_clr = 6'd4, // op_a with the bits of op_b cleared.
		op_eq  = 6'd5,
		op_lt  = 6'd6,
		op_ltu = 6'd7,
		op_xor = 6'd8,
		op_sll = 6'd9,
		op_srl = 6'd10,
		op_sra = 6'd11
	} alu_op_t;

endpackage

// File: fwrisc_alu.sv
`include "fwrisc_exec_consts.svh"

module fwrisc_alu (
	input  logic [`FWRISC_XLEN-1:0]  op_a,
	input  logic [`FWRISC_XLEN-1:0]  op_b,
	input  fwrisc_exec_pkg::alu_op_t op,
	output logic [`FWRISC_XLEN-1:0]  result
);
	import fwrisc_exec_pkg::*;

	logic eq_flag;
	logic lt_flag;
	logic ltu_flag;

	assign eq_flag  = (op_a == op_b);
	assign lt_flag  = ($signed(op_a) < $signed(op_b)); // signed compare.
	assign ltu_flag = (op_a < op_b);

	always_comb begin
		case (op)
			op_add: begin
				result = op_a + op_b;
			end
			op_sub: begin
				result = op_a - op_b;
			end
			op_and: begin
				result = op_a & op_b;
			end
			op_or: begin
				result = op_a | op_b;
			end
			op_clr: begin
				result = op_a & ~op_b; // same as op_a ^ (op_a & op_b).
			end
			op_xor: begin
				result = op_a ^ op_b;
			end
			// the compares write a single flag bit, zero extended.
			op_eq: begin
				result = {{(`FWRISC_XLEN-1){1'b0}}, eq_flag};
			end
			op_lt: begin
				result = {{(`FWRISC_XLEN-1){1'b0}}, lt_flag};
			end
			op_ltu: begin
				result = {{(`FWRISC_XLEN-1){1'b0}}, ltu_flag};
			end
			default: begin
				result = '0; // shift codes and unused codes.
			end
		endcase
	end

endmodule

// File: fwrisc_shifter.sv
`include "fwrisc_exec_consts.svh"

module fwrisc_shifter (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       start,
	input  logic [`FWRISC_XLEN-1:0]    data,
	input  logic [`FWRISC_SHAMT_W-1:0] amount,
	input  fwrisc_exec_pkg::alu_op_t   op,
	output logic                       busy,
	output logic                       done,
	output logic [`FWRISC_XLEN-1:0]    result
);
	import fwrisc_exec_pkg::*;

	logic [`FWRISC_XLEN-1:0]    shift_q;
	logic [`FWRISC_SHAMT_W-1:0] count_q;
	alu_op_t                    op_q;

	function automatic logic [`FWRISC_XLEN-1:0] shift_one(
		input logic [`FWRISC_XLEN-1:0] value,
		input alu_op_t                 kind
	);
		case (kind)
			op_sll:  return {value[`FWRISC_XLEN-2:0], 1'b0};
			op_srl:  return {1'b0, value[`FWRISC_XLEN-1:1]};
			op_sra:  return {value[`FWRISC_XLEN-1], value[`FWRISC_XLEN-1:1]};
			default: return value;
		endcase
	endfunction

	// a zero amount needs no step and finishes in the start cycle.
	assign done   = (start && amount == '0) || (busy && count_q == '0);
	assign result = busy ? shift_q : data;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy    <= 1'b0;
			count_q <= '0;
		end else if (start && amount != '0) begin
			// the first step is taken while loading.
			busy    <= 1'b1;
			count_q <= amount - 1'b1;
		end else if (busy) begin
			if (count_q == '0) begin
				busy <= 1'b0;
			end else begin
				count_q <= count_q - 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			shift_q <= shift_one(data, op);
			op_q    <= op;
		end else if (busy && count_q != '0) begin
			shift_q <= shift_one(shift_q, op_q); // one bit per cycle.
		end
	end

endmodule

// File: fwrisc_pc_next.sv
`include "fwrisc_exec_consts.svh"

module fwrisc_pc_next (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    advance,
	input  logic                    instr_c,
	input  logic                    jump,
	input  logic [`FWRISC_XLEN-1:0] target,
	output logic [`FWRISC_XLEN-1:1] pc,
	output logic                    pc_seq,
	output logic [`FWRISC_XLEN-1:0] ret_addr
);

	logic [`FWRISC_XLEN-1:0] step;

	// compressed instructions are two bytes long.
	assign step     = instr_c ? `FWRISC_XLEN'd2 : `FWRISC_XLEN'd4;
	assign ret_addr = {pc, 1'b0} + step;

	always_ff @(posedge clock) begin
		if (reset) begin
			pc     <= `FWRISC_RESET_VEC;
			pc_seq <= 1'b0;
		end else if (advance) begin
			if (jump) begin
				pc <= target[`FWRISC_XLEN-1:1]; // bit 0 of the target is dropped.
			end else begin
				pc <= ret_addr[`FWRISC_XLEN-1:1];
			end
			pc_seq <= ~jump;
		end
	end

endmodule

// File: fwrisc_exec_ctrl.sv
`include "fwrisc_exec_consts.svh"

module fwrisc_exec_ctrl (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          decode_valid,
	input  fwrisc_exec_pkg::exec_op_type_t op_type,
	input  fwrisc_exec_pkg::alu_op_t      op,
	input  logic [`FWRISC_XLEN-1:0]       op_a,
	input  logic [`FWRISC_XLEN-1:0]       op_b,
	input  logic [`FWRISC_XLEN-1:0]       op_c,
	input  logic [`FWRISC_RADDR_W-1:0]    rd_raddr,
	input  logic                          instr_c,
	output fwrisc_exec_pkg::alu_op_t      alu_op,
	output logic [`FWRISC_XLEN-1:0]       alu_a,
	output logic [`FWRISC_XLEN-1:0]       alu_b,
	input  logic [`FWRISC_XLEN-1:0]       alu_result,
	output logic                          shift_start,
	input  logic                          shift_done,
	input  logic [`FWRISC_XLEN-1:0]       shift_result,
	output logic                          pc_advance,
	output logic                          pc_jump,
	output logic [`FWRISC_XLEN-1:0]       pc_target,
	input  logic [`FWRISC_XLEN-1:0]       ret_addr,
	output logic                          instr_c_q,
	output logic                          instr_complete,
	output logic [`FWRISC_RADDR_W-1:0]    rd_waddr,
	output logic [`FWRISC_XLEN-1:0]       rd_wdata,
	output logic                          rd_wen
);
	import fwrisc_exec_pkg::*;

	// low while idle, high while a shift is in flight.
	logic busy_q;

	logic [`FWRISC_RADDR_W-1:0] rd_raddr_q;
	logic                       instr_c_r;
	logic                       accept;
	logic                       is_shift;
	logic                       finish;
	logic [`FWRISC_RADDR_W-1:0] waddr_cur;
	logic [`FWRISC_XLEN-1:0]    wdata_cur;

	assign accept   = decode_valid && !busy_q;
	assign is_shift = (op_type == op_type_shift);

	// the ALU works on the operands of the decode cycle.
	assign alu_op = op;
	assign alu_a  = op_a;
	assign alu_b  = op_b;

	assign shift_start = accept && is_shift;

	// arithmetic and jump finish in the decode cycle and shifts finish on shift_done.
	// the write-back registers then present the result one edge later.
	assign finish = (accept && !is_shift) || shift_done;

	assign pc_advance = finish; // pc moves on the edge that raises instr_complete.
	assign pc_jump    = !busy_q && (op_type == op_type_jump);
	assign pc_target  = op_c;

	// decode inputs hold only in the decode cycle, so a shift uses the captured copy.
	assign instr_c_q = busy_q ? instr_c_r : instr_c;
	assign waddr_cur = busy_q ? rd_raddr_q : rd_raddr;

	always_comb begin
		if (shift_done) begin
			wdata_cur = shift_result;
		end else if (op_type == op_type_jump) begin
			wdata_cur = ret_addr; // link address.
		end else begin
			wdata_cur = alu_result;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			busy_q         <= 1'b0;
			instr_complete <= 1'b0;
			rd_wen         <= 1'b0;
		end else begin
			instr_complete <= finish;
			rd_wen         <= finish && (waddr_cur != '0); // x0 is never written.
			if (shift_start && !shift_done) begin
				busy_q <= 1'b1;
			end else if (shift_done) begin
				busy_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			rd_raddr_q <= rd_raddr;
			instr_c_r  <= instr_c;
		end
		if (finish) begin
			rd_waddr <= waddr_cur;
			rd_wdata <= wdata_cur;
		end
	end

endmodule

// File: fwrisc_exec.sv
`include "fwrisc_exec_consts.svh"

module fwrisc_exec (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          decode_valid,
	input  logic                          instr_c,
	input  fwrisc_exec_pkg::exec_op_type_t op_type,
	input  fwrisc_exec_pkg::alu_op_t      op,
	input  logic [`FWRISC_XLEN-1:0]       op_a,
	input  logic [`FWRISC_XLEN-1:0]       op_b,
	input  logic [`FWRISC_XLEN-1:0]       op_c,
	input  logic [`FWRISC_RADDR_W-1:0]    rd_raddr,
	output logic                          instr_complete,
	output logic [`FWRISC_RADDR_W-1:0]    rd_waddr,
	output logic [`FWRISC_XLEN-1:0]       rd_wdata,
	output logic                          rd_wen,
	output logic [`FWRISC_XLEN-1:1]       pc,
	output logic                          pc_seq
);
	import fwrisc_exec_pkg::*;

	alu_op_t                 alu_op;
	logic [`FWRISC_XLEN-1:0] alu_a;
	logic [`FWRISC_XLEN-1:0] alu_b;
	logic [`FWRISC_XLEN-1:0] alu_result;
	logic                    shift_start;
	logic                    shift_done;
	logic [`FWRISC_XLEN-1:0] shift_result;
	logic                    pc_advance;
	logic                    pc_jump;
	logic [`FWRISC_XLEN-1:0] pc_target;
	logic [`FWRISC_XLEN-1:0] ret_addr;
	logic                    instr_c_q;

	fwrisc_exec_ctrl u_ctrl (
		.clock          (clock),
		.reset          (reset),
		.decode_valid   (decode_valid),
		.op_type        (op_type),
		.op             (op),
		.op_a           (op_a),
		.op_b           (op_b),
		.op_c           (op_c),
		.rd_raddr       (rd_raddr),
		.instr_c        (instr_c),
		.alu_op         (alu_op),
		.alu_a          (alu_a),
		.alu_b          (alu_b),
		.alu_result     (alu_result),
		.shift_start    (shift_start),
		.shift_done     (shift_done),
		.shift_result   (shift_result),
		.pc_advance     (pc_advance),
		.pc_jump        (pc_jump),
		.pc_target      (pc_target),
		.ret_addr       (ret_addr),
		.instr_c_q      (instr_c_q),
		.instr_complete (instr_complete),
		.rd_waddr       (rd_waddr),
		.rd_wdata       (rd_wdata),
		.rd_wen         (rd_wen)
	);

	fwrisc_alu u_alu (
		.op_a   (alu_a),
		.op_b   (alu_b),
		.op     (alu_op),
		.result (alu_result)
	);

	// the shifter samples the decode-cycle operands together with shift_start.
	fwrisc_shifter u_shifter (
		.clock  (clock),
		.reset  (reset),
		.start  (shift_start),
		.data   (op_a),
		.amount (op_b[`FWRISC_SHAMT_W-1:0]),
		.op     (op),
		.busy   (),
		.done   (shift_done),
		.result (shift_result)
	);

	fwrisc_pc_next u_pc_next (
		.clock    (clock),
		.reset    (reset),
		.advance  (pc_advance),
		.instr_c  (instr_c_q),
		.jump     (pc_jump),
		.target   (pc_target),
		.pc       (pc),
		.pc_seq   (pc_seq),
		.ret_addr (ret_addr)
	);

endmodule

// File: tb_fwrisc_exec_model.svh
`ifndef TB_FWRISC_EXEC_MODEL_SVH
`define TB_FWRISC_EXEC_MODEL_SVH

// signed order from the sign bits first, then the magnitude.
function automatic logic signed_less(
	input logic [`FWRISC_XLEN-1:0] a,
	input logic [`FWRISC_XLEN-1:0] b
);
	if (a[`FWRISC_XLEN-1] != b[`FWRISC_XLEN-1]) begin
		return a[`FWRISC_XLEN-1]; // the negative one is smaller.
	end
	return (a < b);
endfunction

function automatic logic [`FWRISC_XLEN-1:0] arith_result(
	input alu_op_t                 kind,
	input logic [`FWRISC_XLEN-1:0] a,
	input logic [`FWRISC_XLEN-1:0] b
);
	case (kind)
		op_add:  return a + b;
		op_sub:  return a - b;
		op_and:  return a & b;
		op_or:   return a | b;
		op_clr:  return a & ~b;
		op_eq:   return (a == b) ? 1 : 0;
		op_lt:   return signed_less(a, b) ? 1 : 0;
		op_ltu:  return (a < b) ? 1 : 0;
		op_xor:  return a ^ b;
		default: return '0;
	endcase
endfunction

function automatic logic [`FWRISC_XLEN-1:0] shifted_value(
	input alu_op_t                     kind,
	input logic [`FWRISC_XLEN-1:0]     a,
	input logic [`FWRISC_SHAMT_W-1:0]  amount
);
	case (kind)
		op_sll:  return a << amount;
		op_srl:  return a >> amount;
		op_sra:  return $signed(a) >>> amount;
		default: return '0;
	endcase
endfunction

// byte address of the next sequential instruction.
function automatic logic [`FWRISC_XLEN-1:0] link_address(
	input logic [`FWRISC_XLEN-1:1] cur_pc,
	input logic                    compressed
);
	return {cur_pc, 1'b0} + (compressed ? 32'd2 : 32'd4);
endfunction

`endif

// File: tb_fwrisc_exec.sv
`include "fwrisc_exec_consts.svh"

module tb_fwrisc_exec;
	import fwrisc_exec_pkg::*;

	`include "tb_fwrisc_exec_model.svh"

	localparam int num_instr      = 2000;
	localparam int timeout_cycles = 64;

	logic                       clock;
	logic                       reset;
	logic                       decode_valid;
	logic                       instr_c;
	exec_op_type_t              op_type;
	alu_op_t                    op;
	logic [`FWRISC_XLEN-1:0]    op_a;
	logic [`FWRISC_XLEN-1:0]    op_b;
	logic [`FWRISC_XLEN-1:0]    op_c;
	logic [`FWRISC_RADDR_W-1:0] rd_raddr;
	logic                       instr_complete;
	logic [`FWRISC_RADDR_W-1:0] rd_waddr;
	logic [`FWRISC_XLEN-1:0]    rd_wdata;
	logic                       rd_wen;
	logic [`FWRISC_XLEN-1:1]    pc;
	logic                       pc_seq;

	logic [15:0]                lfsr_q;
	logic [`FWRISC_XLEN-1:1]    model_pc; // pc as the model expects it.

	fwrisc_exec dut (.*);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 16'hB400;
		end
		return state >> 1;
	endfunction

	function automatic logic [31:0] take_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value  = {value[30:0], lfsr_q[0]};
			lfsr_q = lfsr_step(lfsr_q);
		end
		return value;
	endfunction

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at the first error.");
	endtask

	task automatic check_data(input string name, input logic [`FWRISC_XLEN-1:0] got,
			input logic [`FWRISC_XLEN-1:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_addr(input string name, input logic [`FWRISC_RADDR_W-1:0] got,
			input logic [`FWRISC_RADDR_W-1:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_pc(input string name, input logic [`FWRISC_XLEN-2:0] got,
			input logic [`FWRISC_XLEN-2:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_idle();
		check_bit("instr_complete", instr_complete, 1'b0);
		check_bit("rd_wen", rd_wen, 1'b0);
	endtask

	// called on a falling edge, returns on the falling edge that shows instr_complete.
	task automatic issue_random();
		logic [1:0]                 kind;
		logic [1:0]                 amount_sel;
		logic [5:0]                 code;
		int                         latency;
		int                         cycles;
		logic [`FWRISC_XLEN-1:0]    exp_data;
		logic [`FWRISC_XLEN-1:0]    link;
		logic [`FWRISC_RADDR_W-1:0] exp_waddr;
		logic [`FWRISC_XLEN-1:1]    exp_pc;
		logic                       exp_seq;
		kind     = take_bits(2);
		instr_c  = take_bits(1);
		rd_raddr = take_bits(`FWRISC_RADDR_W);
		op_a     = take_bits(32);
		op_b     = take_bits(32);
		op_c     = take_bits(32);
		latency  = 1;
		link     = link_address(model_pc, instr_c);
		if (kind == 2'd2) begin
			op_type    = op_type_shift;
			code       = 6'd9 + take_bits(2) % 3;
			op         = alu_op_t'(code);
			amount_sel = take_bits(2);
			if (amount_sel == 2'd0) begin
				op_b[4:0] = 5'd0;
			end else if (amount_sel == 2'd1) begin
				op_b[4:0] = 5'd31;
			end
			latency  = op_b[4:0] + 1;
			exp_data = shifted_value(op, op_a, op_b[4:0]);
		end else if (kind == 2'd3) begin
			op_type  = op_type_jump;
			op       = op_add;
			exp_data = link; // the return address.
		end else begin
			op_type = op_type_arith;
			code    = take_bits(4) % 9;
			op      = alu_op_t'(code);
			if (take_bits(3) == 0) begin
				op_b = op_a; // lets eq see equal operands now and then.
			end
			exp_data = arith_result(op, op_a, op_b);
		end
		exp_waddr    = rd_raddr;
		exp_seq      = (op_type != op_type_jump);
		exp_pc       = exp_seq ? link[`FWRISC_XLEN-1:1] : op_c[`FWRISC_XLEN-1:1];
		decode_valid = 1'b1;
		cycles       = 0;
		do begin
			@(negedge clock);
			// decode holds its operands for the strobe cycle only.
			decode_valid = 1'b0;
			instr_c      = 1'bx;
			rd_raddr     = 'x;
			op_a         = 'x;
			op_b         = 'x;
			op_c         = 'x;
			cycles++;
		end while (instr_complete !== 1'b1 && cycles < timeout_cycles);
		if (instr_complete !== 1'b1) begin
			fail_run("instr_complete did not arrive within 64 cycles of decode_valid.");
		end
		if (cycles != latency) begin
			fail_run($sformatf("Mismatch latency: got 0x%h, expected 0x%h", cycles, latency));
		end
		check_addr("rd_waddr", rd_waddr, exp_waddr);
		check_data("rd_wdata", rd_wdata, exp_data);
		check_bit("rd_wen", rd_wen, exp_waddr != 0);
		model_pc = exp_pc;
		check_pc("pc", pc, model_pc);
		check_bit("pc_seq", pc_seq, exp_seq);
	endtask

	initial begin
		reset        = 1'b1;
		decode_valid = 1'b0;
		instr_c      = 1'b0;
		op_type      = op_type_arith;
		op           = op_add;
		op_a         = '0;
		op_b         = '0;
		op_c         = '0;
		rd_raddr     = '0;
		lfsr_q       = 16'd48709;
		model_pc     = `FWRISC_RESET_VEC;
		repeat (8) @(negedge clock);
		reset = 1'b0;
		repeat (4) begin
			@(negedge clock);
			check_pc("pc", pc, `FWRISC_RESET_VEC);
			check_bit("pc_seq", pc_seq, 1'b0);
			check_idle();
		end
		for (int n = 0; n < num_instr; n++) begin
			issue_random();
			if (take_bits(3) == 0) begin
				@(negedge clock); // a gap shows that instr_complete is one cycle wide.
				check_idle();
			end
		end
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: src.f
+incdir+.
fwrisc_exec_pkg.sv
fwrisc_alu.sv
fwrisc_shifter.sv
fwrisc_pc_next.sv
fwrisc_exec_ctrl.sv
fwrisc_exec.sv
tb_fwrisc_exec.sv
